// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps
TOP := memSubsystemTb
FILELIST := src.f
OBJDIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== dv/memGolden.txt ====
// op address storeData expLoadData expAddrError, all hex
// op: 0 loadWord, 1 loadByte, 2 loadByteUnsigned, 3 storeWord, 4 storeByte
0 00000000 00000000 00000000 0
0 000001FC 00000000 00000000 0
3 00000000 12345678 00000000 0
0 00000000 00000000 12345678 0
3 000001FC DEADBEEF 00000000 0
0 000001FC 00000000 DEADBEEF 0
1 00000000 00000000 00000012 0
2 00000003 00000000 00000078 0
3 00000010 80FF7F01 00000000 0
1 00000010 00000000 FFFFFF80 0
2 00000010 00000000 00000080 0
1 00000011 00000000 FFFFFFFF 0
2 00000011 00000000 000000FF 0
1 00000012 00000000 0000007F 0
2 00000013 00000000 00000001 0
4 00000021 000000A5 00000000 0
0 00000020 00000000 00A50000 0
4 00000023 0000003C 00000000 0
0 00000020 00000000 00A5003C 0
4 00000020 123456C3 00000000 0
0 00000020 00000000 C3A5003C 0
4 00000022 FFFFFF96 00000000 0
0 00000020 00000000 C3A5963C 0
1 00000022 00000000 FFFFFF96 0
2 00000022 00000000 00000096 0
4 00000001 000000AB 00000000 0
0 00000000 00000000 12AB5678 0
0 00000002 00000000 00000000 1
3 00000001 11111111 00000000 1
0 00000000 00000000 12AB5678 0
3 00000006 22222222 00000000 1
0 00000004 00000000 00000000 0
3 00000200 AAAAAAAA 00000000 1
0 00000200 00000000 00000000 1
1 00000200 00000000 00000000 1
2 000003FF 00000000 00000000 1
4 00000200 00000055 00000000 1
4 FFFFFFFC 00000077 00000000 1
0 000001FC 00000000 DEADBEEF 0
0 00000201 00000000 00000000 1
4 000001FF 0000005A 00000000 0
0 000001FC 00000000 DEADBE5A 0
1 000001FF 00000000 0000005A 0
3 00000100 FFFFFFFF 00000000 0
0 00000100 00000000 FFFFFFFF 0

// ==== dv/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;

	localparam int DW = memPkg::DATA_WIDTH;

	logic memEnable;
	logic reset;
	logic start;
	memPkg::memOpE op;
	logic [DW-1:0] address;
	logic [DW-1:0] storeData;
	logic [DW-1:0] loadData;
	logic addrError;
	logic done;
	logic busy;

	// one entry per request line of the golden file
	logic [2:0] opList [$];
	logic [DW-1:0] addressList [$];
	logic [DW-1:0] storeList [$];
	logic [DW-1:0] expLoadList [$];
	logic expErrorList [$];
	int lineNumbers [$];

	int lineCount = 0;
	bit fileLoaded = 1'b0;
	int doneCount = 0;
	int extraStarts = 0;
	logic [31:0] lfsrState;

	memSubsystem memSubsystem_i (
		.memEnable(memEnable),
		.reset    (reset),
		.start    (start),
		.op       (op),
		.address  (address),
		.storeData(storeData),
		.loadData (loadData),
		.addrError(addrError),
		.done     (done),
		.busy     (busy)
	);

	initial begin
		memEnable = 1'b0;
		forever #10 memEnable = ~memEnable;
	end

	always @(negedge memEnable) begin
		if (!reset && done) begin
			doneCount++;
		end
	end

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic takeBit(output logic b);
		b = lfsrState[0];
		lfsrState = lfsrNext(lfsrState);
	endtask

	task automatic failOnMismatch(input string testName, input logic [DW-1:0] expected,
			input logic [DW-1:0] actual);
		$display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
		$display("TEST FAIL");
		$fatal(1, "value mismatch in %s", testName);
	endtask

	task automatic abortRun(input string what);
		$display("ERROR: %s", what);
		$display("TEST FAIL");
		$fatal(1, "%s", what);
	endtask

	task automatic loadGolden();
		int fd;
		int n;
		int lineNo;
		string text;
		logic [31:0] opNum;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expLoad;
		logic [31:0] expErr;
		fd = $fopen("dv/memGolden.txt", "r");
		if (fd == 0) begin
			abortRun("cannot open dv/memGolden.txt");
		end
		lineNo = 0;
		while (!$feof(fd)) begin
			text = "";
			n = $fgets(text, fd);
			lineNo++;
			if (n <= 0) begin
				continue;
			end
			if (text.len() >= 2 && text.substr(0, 1) == "//") begin
				continue;
			end
			n = $sscanf(text, "%h %h %h %h %h", opNum, addr, data, expLoad, expErr);
			if (n == 5) begin
				opList.push_back(opNum[2:0]);
				addressList.push_back(addr);
				storeList.push_back(data);
				expLoadList.push_back(expLoad);
				expErrorList.push_back(expErr[0]);
				lineNumbers.push_back(lineNo);
			end else if (n > 0) begin
				abortRun($sformatf("malformed golden line %0d", lineNo));
			end
		end
		$fclose(fd);
		lineCount = opList.size();
	endtask

	task automatic runRequest(input int idx);
		logic pulse;
		string testName;
		testName = $sformatf("line %0d", lineNumbers[idx]);
		@(posedge memEnable);
		#2;
		start = 1'b1;
		op = memPkg::memOpE'(opList[idx]);
		address = addressList[idx];
		storeData = storeList[idx];
		@(posedge memEnable);
		#2;
		start = 1'b0;
		// junk on the inputs, only the accepted edge counts
		address = '1;
		storeData = '1;
		assert (busy) else abortRun({"busy did not rise after start on ", testName});
		while (!done) begin
			// stray start while busy, must be ignored
			takeBit(pulse);
			if (busy && pulse) begin
				start = 1'b1;
				extraStarts++;
			end
			@(posedge memEnable);
			#2;
			start = 1'b0;
		end
		assert (loadData === expLoadList[idx])
			else failOnMismatch({testName, " loadData"}, expLoadList[idx], loadData);
		assert (addrError === expErrorList[idx])
			else failOnMismatch({testName, " addrError"}, DW'(expErrorList[idx]), DW'(addrError));
	endtask

	initial begin : watchdog
		int limit;
		wait (fileLoaded);
		limit = lineCount * 20 + 1000;
		repeat (limit) @(posedge memEnable);
		$display("ERROR: done never arrived, run stopped after %0d cycles", limit);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [2:0] gap;
		logic b;
		reset = 1'b1;
		start = 1'b0;
		op = memPkg::opLoadWord;
		address = '0;
		storeData = '0;
		lfsrState = 32'h159c_ec9a;
		loadGolden();
		fileLoaded = 1'b1;
		repeat (16) @(posedge memEnable);
		#2;
		reset = 1'b0;
		assert (!done && !busy && !addrError && loadData == '0)
			else abortRun("outputs not cleared by reset");
		for (int i = 0; i < lineCount; i++) begin
			gap = '0;
			repeat (3) begin
				takeBit(b);
				gap = {gap[1:0], b};
			end
			repeat (gap) @(posedge memEnable);
			runRequest(i);
		end
		// room for a late extra done
		repeat (4) @(posedge memEnable);
		if (doneCount == lineCount) begin
			$display("%0d requests done, %0d extra starts ignored", lineCount, extraStarts);
			$display("TEST PASS");
			$finish;
		end else begin
			failOnMismatch("done count", DW'(lineCount), DW'(doneCount));
		end
	end

endmodule

// ==== src.f ====
src/memPkg.sv
src/byteMemory.sv
src/memInterfaceUnit.sv
src/memSubsystem.sv
dv/memSubsystemTb.sv

// ==== src/byteMemory.sv ====
`timescale 1ns/1ps

module byteMemory #(
	parameter int DEPTH = 512,
	parameter int WORD_CYCLES = 3,
	parameter int BYTE_CYCLES = 2
) (
	input  logic                          memEnable,
	input  logic                          reset,
	input  logic                          memRequest,
	input  logic                          rw,
	input  logic                          byteMode,
	input  logic [$clog2(DEPTH)-1:0]      memAddress,
	input  logic [memPkg::DATA_WIDTH-1:0] memDataIn,
	output logic [memPkg::DATA_WIDTH-1:0] memDataOut,
	output logic                          moc
);

	localparam int DW = memPkg::DATA_WIDTH;
	localparam int ADDR_W = $clog2(DEPTH);
	localparam int BYTES_PER_WORD = DW / 8;
	localparam int MAX_CYCLES = (WORD_CYCLES > BYTE_CYCLES) ? WORD_CYCLES : BYTE_CYCLES;
	localparam int CNT_W = $clog2(MAX_CYCLES + 1);

	typedef enum logic {
		stIdle,
		stBusy
	} memStateE;

	memStateE state;
	logic [CNT_W-1:0] count;
	logic firstCycle;

	logic [7:0] mem [DEPTH];

	// request held for the access cycle
	logic [ADDR_W-1:0] reqAddress;
	logic reqRw;
	logic reqByte;
	logic [DW-1:0] reqData;

	// moc low phase, counted down from the access length
	always_ff @(posedge memEnable) begin
		if (reset) begin
			state <= stIdle;
			moc <= 1'b1;
			count <= '0;
			firstCycle <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (memRequest) begin
						state <= stBusy;
						moc <= 1'b0;
						firstCycle <= 1'b1;
						count <= byteMode ? CNT_W'(BYTE_CYCLES) : CNT_W'(WORD_CYCLES);
					end
				end
				stBusy: begin
					firstCycle <= 1'b0;
					if (count == CNT_W'(1)) begin
						state <= stIdle;
						moc <= 1'b1;
						count <= '0;
					end else begin
						count <= count - CNT_W'(1);
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge memEnable) begin
		if (state == stIdle && memRequest) begin
			reqAddress <= memAddress;
			reqRw <= rw;
			reqByte <= byteMode;
			reqData <= memDataIn;
		end
	end

	// storage, written in the first busy cycle
	always_ff @(posedge memEnable) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= 8'h00;
			end
		end else if (firstCycle && reqRw) begin
			if (reqByte) begin
				mem[reqAddress] <= reqData[DW-1 -: 8];
			end else begin
				// big endian, most significant byte at the lowest address
				for (int b = 0; b < BYTES_PER_WORD; b++) begin
					mem[reqAddress + ADDR_W'(b)] <= reqData[DW-1-8*b -: 8];
				end
			end
		end
	end

	always_ff @(posedge memEnable) begin
		if (firstCycle && !reqRw) begin
			if (reqByte) begin
				memDataOut <= {{(DW-8){1'b0}}, mem[reqAddress]};
			end else begin
				for (int b = 0; b < BYTES_PER_WORD; b++) begin
					memDataOut[DW-1-8*b -: 8] <= mem[reqAddress + ADDR_W'(b)];
				end
			end
		end
	end

	// the unit must wait for moc before the next request
	assert property (@(posedge memEnable) disable iff (reset) memRequest |-> moc)
		else $error("byteMemory: memRequest while moc low");

	assert property (@(posedge memEnable) disable iff (reset)
		state == stBusy |-> count <= CNT_W'(WORD_CYCLES) && count != '0)
		else $error("byteMemory: counter out of range");

endmodule

// ==== src/memInterfaceUnit.sv ====
`timescale 1ns/1ps

module memInterfaceUnit #(
	parameter int DEPTH = 512
) (
	input  logic                          memEnable,
	input  logic                          reset,
	input  logic                          start,
	input  memPkg::memOpE                 op,
	input  logic [memPkg::DATA_WIDTH-1:0] address,
	input  logic [memPkg::DATA_WIDTH-1:0] storeData,
	input  logic [memPkg::DATA_WIDTH-1:0] memDataOut,
	input  logic                          moc,
	output logic [memPkg::DATA_WIDTH-1:0] loadData,
	output logic                          addrError,
	output logic                          done,
	output logic                          busy,
	output logic                          memRequest,
	output logic                          rw,
	output logic                          byteMode,
	output logic [$clog2(DEPTH)-1:0]      memAddress,
	output logic [memPkg::DATA_WIDTH-1:0] memDataIn
);

	localparam int DW = memPkg::DATA_WIDTH;
	localparam int ADDR_W = $clog2(DEPTH);

	typedef enum logic [2:0] {
		stIdle,
		stCheck,
		stWaitLow,
		stWaitHigh,
		stFinish
	} unitStateE;

	unitStateE state;

	// request slot
	memPkg::memOpE opReg;
	logic [DW-1:0] addressReg;
	logic [DW-1:0] storeReg;

	logic accept;
	logic isWord;
	logic checkError;
	logic [DW-1:0] extendedLoad;

	assign done = (state == stFinish);
	assign busy = (state == stCheck) || (state == stWaitLow) || (state == stWaitHigh);
	assign accept = start && !busy;

	always_comb begin
		isWord = (opReg == memPkg::opLoadWord) || (opReg == memPkg::opStoreWord);
		checkError = (addressReg >= DW'(DEPTH)) || (isWord && addressReg[1:0] != 2'b00);
	end

	// byte loads come back in the low lane
	always_comb begin
		case (opReg)
			memPkg::opLoadWord:         extendedLoad = memDataOut;
			memPkg::opLoadByte:         extendedLoad = {{(DW-8){memDataOut[7]}}, memDataOut[7:0]};
			memPkg::opLoadByteUnsigned: extendedLoad = {{(DW-8){1'b0}}, memDataOut[7:0]};
			default:                    extendedLoad = '0;
		endcase
	end

	always_ff @(posedge memEnable) begin
		if (reset) begin
			state <= stIdle;
			memRequest <= 1'b0;
			loadData <= '0;
			addrError <= 1'b0;
		end else begin
			memRequest <= 1'b0;
			case (state)
				stIdle, stFinish: begin
					if (start) begin
						state <= stCheck;
					end else begin
						state <= stIdle;
					end
				end
				stCheck: begin
					if (checkError) begin
						state <= stFinish;
						addrError <= 1'b1;
						loadData <= '0;
					end else begin
						state <= stWaitLow;
						memRequest <= 1'b1;
					end
				end
				stWaitLow: begin
					if (!moc) begin
						state <= stWaitHigh;
					end
				end
				stWaitHigh: begin
					// memory done and data valid from this cycle on
					if (moc) begin
						state <= stFinish;
						addrError <= 1'b0;
						loadData <= extendedLoad;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge memEnable) begin
		if (accept) begin
			opReg <= op;
			addressReg <= address;
			storeReg <= storeData;
		end
	end

	// memory side strobes held until the next request
	always_ff @(posedge memEnable) begin
		if (state == stCheck && !checkError) begin
			memAddress <= addressReg[ADDR_W-1:0];
			case (opReg)
				memPkg::opStoreWord: begin
					rw <= 1'b1;
					byteMode <= 1'b0;
					memDataIn <= storeReg;
				end
				memPkg::opStoreByte: begin
					rw <= 1'b1;
					byteMode <= 1'b1;
					memDataIn <= {storeReg[7:0], {(DW-8){1'b0}}};
				end
				memPkg::opLoadByte, memPkg::opLoadByteUnsigned: begin
					rw <= 1'b0;
					byteMode <= 1'b1;
					memDataIn <= '0;
				end
				default: begin
					rw <= 1'b0;
					byteMode <= 1'b0;
					memDataIn <= '0;
				end
			endcase
		end
	end

	assert property (@(posedge memEnable) disable iff (reset) done |=> !done)
		else $error("memInterfaceUnit: done wider than one cycle");

	assert property (@(posedge memEnable) disable iff (reset)
		memRequest |-> (addressReg[DW-1:ADDR_W] == '0) && (byteMode || memAddress[1:0] == 2'b00))
		else $error("memInterfaceUnit: memRequest for an illegal access");

endmodule

// ==== src/memPkg.sv ====
package memPkg;

	// width of one data word, shared by the unit, the memory and the testbench
	parameter int DATA_WIDTH = 32;

	// access opcodes as driven on the op port
	typedef enum logic [2:0] {
		opLoadWord         = 3'd0,
		opLoadByte         = 3'd1,
		opLoadByteUnsigned = 3'd2,
		opStoreWord        = 3'd3,
		opStoreByte        = 3'd4
	} memOpE;

endpackage

// ==== src/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem #(
	parameter int DEPTH = 512,
	parameter int WORD_CYCLES = 3,
	parameter int BYTE_CYCLES = 2
) (
	input  logic                          memEnable,
	input  logic                          reset,
	input  logic                          start,
	input  memPkg::memOpE                 op,
	input  logic [memPkg::DATA_WIDTH-1:0] address,
	input  logic [memPkg::DATA_WIDTH-1:0] storeData,
	output logic [memPkg::DATA_WIDTH-1:0] loadData,
	output logic                          addrError,
	output logic                          done,
	output logic                          busy
);

	localparam int ADDR_W = $clog2(DEPTH);

	// unit to memory
	logic memRequest;
	logic rw;
	logic byteMode;
	logic [ADDR_W-1:0] memAddress;
	logic [memPkg::DATA_WIDTH-1:0] memDataIn;
	logic [memPkg::DATA_WIDTH-1:0] memDataOut;
	logic moc;

	memInterfaceUnit #(
		.DEPTH(DEPTH)
	) memInterfaceUnit_i (
		.memEnable (memEnable),
		.reset     (reset),
		.start     (start),
		.op        (op),
		.address   (address),
		.storeData (storeData),
		.memDataOut(memDataOut),
		.moc       (moc),
		.loadData  (loadData),
		.addrError (addrError),
		.done      (done),
		.busy      (busy),
		.memRequest(memRequest),
		.rw        (rw),
		.byteMode  (byteMode),
		.memAddress(memAddress),
		.memDataIn (memDataIn)
	);

	byteMemory #(
		.DEPTH      (DEPTH),
		.WORD_CYCLES(WORD_CYCLES),
		.BYTE_CYCLES(BYTE_CYCLES)
	) byteMemory_i (
		.memEnable (memEnable),
		.reset     (reset),
		.memRequest(memRequest),
		.rw        (rw),
		.byteMode  (byteMode),
		.memAddress(memAddress),
		.memDataIn (memDataIn),
		.memDataOut(memDataOut),
		.moc       (moc)
	);

endmodule
